// ==== Bender.yml ====
package:
  name: backend

sources:
  - backendPkg.sv
  - renameStage.sv
  - intIssueQueue.sv
  - intExecute.sv
  - reorderBuffer.sv
  - backend.sv
  - target: test
    files:
      - backendTb.sv

// ==== backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend import backendPkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  instValid_i,
    input  aluOp_e                instOp_i,
    input  logic [ARCH_IDX_W-1:0] instRd_i,
    input  logic [ARCH_IDX_W-1:0] instRs1_i,
    input  logic [ARCH_IDX_W-1:0] instRs2_i,
    input  logic [IMM_W-1:0]      instImm_i,
    output logic                  stall_o,
    output logic                  commitValid_o,
    output logic [ARCH_IDX_W-1:0] commitRd_o,
    output logic [XLEN-1:0]       commitData_o
);

    logic                  renameFull;
    logic                  iqFull;
    logic                  robFull;
    logic                  accept;

    logic                  dispatchValid;
    aluOp_e                dispOp;
    logic [PHYS_IDX_W-1:0] dispPrs1;
    logic [PHYS_IDX_W-1:0] dispPrs2;
    logic                  dispRs1Ready;
    logic                  dispRs2Ready;
    logic [PHYS_IDX_W-1:0] dispPrd;
    logic [PHYS_IDX_W-1:0] dispOldPrd;
    logic [ARCH_IDX_W-1:0] dispRd;
    logic [IMM_W-1:0]      dispImm;

    logic                  issueValid;
    aluOp_e                issueOp;
    logic [PHYS_IDX_W-1:0] issuePrs1;
    logic [PHYS_IDX_W-1:0] issuePrs2;
    logic [IMM_W-1:0]      issueImm;
    logic [PHYS_IDX_W-1:0] issuePrd;
    logic [ROB_IDX_W-1:0]  issueRobIdx;

    logic                  wbValid;
    logic [PHYS_IDX_W-1:0] wbPrd;
    logic [ROB_IDX_W-1:0]  wbRobIdx;
    logic [XLEN-1:0]       wbData;

    logic [ROB_IDX_W-1:0]  robHead;
    logic [ROB_IDX_W-1:0]  robTail;
    logic [PHYS_IDX_W-1:0] commitOldPrd;

    // an empty free list only matters when rd needs a register
    assign stall_o = (renameFull && instRd_i != '0) || robFull || iqFull;
    assign accept  = instValid_i && !stall_o;

    renameStage rename_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .instValid_i    (accept),
        .instOp_i       (instOp_i),
        .instRd_i       (instRd_i),
        .instRs1_i      (instRs1_i),
        .instRs2_i      (instRs2_i),
        .instImm_i      (instImm_i),
        .wbValid_i      (wbValid),
        .wbPrd_i        (wbPrd),
        .commitValid_i  (commitValid_o),
        .commitOldPrd_i (commitOldPrd),
        .renameFull_o   (renameFull),
        .dispatchValid_o(dispatchValid),
        .dispOp_o       (dispOp),
        .dispPrs1_o     (dispPrs1),
        .dispPrs2_o     (dispPrs2),
        .dispRs1Ready_o (dispRs1Ready),
        .dispRs2Ready_o (dispRs2Ready),
        .dispPrd_o      (dispPrd),
        .dispOldPrd_o   (dispOldPrd),
        .dispRd_o       (dispRd),
        .dispImm_o      (dispImm)
    );

    intIssueQueue iq_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .dispatchValid_i(dispatchValid),
        .dispOp_i       (dispOp),
        .dispPrs1_i     (dispPrs1),
        .dispPrs2_i     (dispPrs2),
        .dispRs1Ready_i (dispRs1Ready),
        .dispRs2Ready_i (dispRs2Ready),
        .dispPrd_i      (dispPrd),
        .dispImm_i      (dispImm),
        .dispRobIdx_i   (robTail),
        .robHead_i      (robHead),
        .wbValid_i      (wbValid),
        .wbPrd_i        (wbPrd),
        .iqFull_o       (iqFull),
        .issueValid_o   (issueValid),
        .issueOp_o      (issueOp),
        .issuePrs1_o    (issuePrs1),
        .issuePrs2_o    (issuePrs2),
        .issueImm_o     (issueImm),
        .issuePrd_o     (issuePrd),
        .issueRobIdx_o  (issueRobIdx)
    );

    intExecute exe_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .issueValid_i (issueValid),
        .issueOp_i    (issueOp),
        .issuePrs1_i  (issuePrs1),
        .issuePrs2_i  (issuePrs2),
        .issueImm_i   (issueImm),
        .issuePrd_i   (issuePrd),
        .issueRobIdx_i(issueRobIdx),
        .wbValid_o    (wbValid),
        .wbPrd_o      (wbPrd),
        .wbRobIdx_o   (wbRobIdx),
        .wbData_o     (wbData)
    );

    reorderBuffer rob_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .dispatchValid_i(dispatchValid),
        .dispRd_i       (dispRd),
        .dispOldPrd_i   (dispOldPrd),
        .wbValid_i      (wbValid),
        .wbRobIdx_i     (wbRobIdx),
        .wbData_i       (wbData),
        .robFull_o      (robFull),
        .robTail_o      (robTail),
        .robHead_o      (robHead),
        .commitValid_o  (commitValid_o),
        .commitRd_o     (commitRd_o),
        .commitData_o   (commitData_o),
        .commitOldPrd_o (commitOldPrd)
    );

endmodule

`default_nettype wire

// ==== backendPkg.sv ====
`default_nettype none

package backendPkg;

    // ##########################################################
    // register and queue sizes
    // ##########################################################

    localparam int ARCH_REGS  = 16;
    localparam int PHYS_REGS  = 32;
    localparam int ARCH_IDX_W = 4;
    localparam int PHYS_IDX_W = 5;

    localparam int ROB_DEPTH  = 16;
    localparam int ROB_IDX_W  = 4;

    localparam int IQ_DEPTH   = 8;
    localparam int IQ_IDX_W   = 3;

    // registers outside the initial mapping
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int FREE_IDX_W = 4;

    localparam int XLEN       = 32;
    localparam int IMM_W      = 16;

    // ##########################################################
    // alu opcodes
    // ##########################################################

    // addi takes the immediate in place of rs2
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SLL  = 3'd5,
        ALU_SRL  = 3'd6,
        ALU_ADDI = 3'd7
    } aluOp_e;

endpackage

`default_nettype wire

// ==== backendTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module backendTb import backendPkg::*; ();

    localparam int NUM_INSTS      = 400;
    localparam int BURST_INSTS    = 100;
    localparam int TIMEOUT_CYCLES = NUM_INSTS * 10;
    localparam int MIN_LATENCY    = 3;

    logic                  clk;
    logic                  reset_i;
    logic                  instValid_i;
    aluOp_e                instOp_i;
    logic [ARCH_IDX_W-1:0] instRd_i;
    logic [ARCH_IDX_W-1:0] instRs1_i;
    logic [ARCH_IDX_W-1:0] instRs2_i;
    logic [IMM_W-1:0]      instImm_i;
    logic                  stall_o;
    logic                  commitValid_o;
    logic [ARCH_IDX_W-1:0] commitRd_o;
    logic [XLEN-1:0]       commitData_o;

    // accepted instructions in program order and read back by commitIdx
    logic [ARCH_IDX_W-1:0] expRd [NUM_INSTS];
    logic [XLEN-1:0]       expData [NUM_INSTS];
    int                    acceptCycle [NUM_INSTS];
    int                    acceptCount;
    int                    commitIdx;
    int                    cycleCount;
    int                    errorCount;
    int                    stallCycles;

    logic [XLEN-1:0]       refRegs [ARCH_REGS];
    logic [ARCH_IDX_W-1:0] recentRd [4];
    logic [31:0]           rngState;

    backend backend_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .instValid_i  (instValid_i),
        .instOp_i     (instOp_i),
        .instRd_i     (instRd_i),
        .instRs1_i    (instRs1_i),
        .instRs2_i    (instRs2_i),
        .instImm_i    (instImm_i),
        .stall_o      (stall_o),
        .commitValid_o(commitValid_o),
        .commitRd_o   (commitRd_o),
        .commitData_o (commitData_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (!reset_i && commitValid_o) begin
            commitIdx <= commitIdx + 1;
        end
    end

    initial begin
        wait (cycleCount >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, %0d of %0d accepted instructions committed",
                 cycleCount, commitIdx, acceptCount);
        $display("*** FAILED ***");
        $finish;
    end

    // ##########################################################
    // reference model and stimulus helpers
    // ##########################################################

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rollRandom(output logic [31:0] value);
        rngState = lcgNext(rngState);
        value    = rngState;
    endtask

    function automatic logic [XLEN-1:0] expectedResult(input aluOp_e op,
                                                       input logic [XLEN-1:0] a,
                                                       input logic [XLEN-1:0] b,
                                                       input logic [IMM_W-1:0] imm);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            default:  return a + {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
        endcase
    endfunction

    // mostly one of the last few destinations and otherwise any register
    function automatic logic [ARCH_IDX_W-1:0] pickSource(input logic [7:0] bits);
        if (bits[1:0] != 2'd0) begin
            return recentRd[bits[3:2]];
        end
        return bits[7:4];
    endfunction

    task automatic idleCycles(input int n);
        instValid_i = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // called 2 ns after an edge and returns 2 ns after the accepting edge
    task automatic offerInst(input aluOp_e op, input logic [ARCH_IDX_W-1:0] rd,
                             input logic [ARCH_IDX_W-1:0] rs1,
                             input logic [ARCH_IDX_W-1:0] rs2,
                             input logic [IMM_W-1:0] imm);
        logic [XLEN-1:0] result;
        instValid_i = 1'b1;
        instOp_i    = op;
        instRd_i    = rd;
        instRs1_i   = rs1;
        instRs2_i   = rs2;
        instImm_i   = imm;
        #1;
        while (stall_o) begin
            stallCycles++;
            @(posedge clk);
            #3;
        end
        result = expectedResult(op, refRegs[rs1], refRegs[rs2], imm);
        expRd[acceptCount]       = rd;
        expData[acceptCount]     = result;
        acceptCycle[acceptCount] = cycleCount;
        acceptCount++;
        if (rd != '0) begin
            refRegs[rd] = result;
        end
        recentRd[3] = recentRd[2];
        recentRd[2] = recentRd[1];
        recentRd[1] = recentRd[0];
        recentRd[0] = rd;
        @(posedge clk);
        #2;
    endtask

    task automatic randomInst(input bit chained);
        logic [31:0]           r;
        logic [31:0]           s;
        logic [31:0]           t;
        logic [ARCH_IDX_W-1:0] rd;
        logic [ARCH_IDX_W-1:0] rs1;
        logic [ARCH_IDX_W-1:0] rs2;
        rollRandom(r);
        rollRandom(s);
        rollRandom(t);
        rd = r[28:25];
        if (chained) begin
            // each one reads the previous result
            rs1 = recentRd[0];
            rs2 = recentRd[1];
            if (rd == '0) begin
                rd = 4'd1;
            end
        end else begin
            rs1 = pickSource(r[24:17]);
            rs2 = pickSource(s[31:24]);
        end
        offerInst(aluOp_e'(r[31:29]), rd, rs1, rs2, t[31:16]);
    endtask

    // ##########################################################
    // checks on the commit port
    // ##########################################################

    quietAfterReset: assert property (@(posedge clk) disable iff (reset_i)
        acceptCount == 0 |-> !commitValid_o && !stall_o)
        else begin
            errorCount++;
            $display("%0t: commit or stall seen before any instruction was accepted", $time);
        end

    commitHasInst: assert property (@(posedge clk) disable iff (reset_i)
        commitValid_o |-> commitIdx < acceptCount)
        else begin
            errorCount++;
            $display("%0t: commit with no accepted instruction left to retire", $time);
        end

    commitRdMatches: assert property (@(posedge clk) disable iff (reset_i)
        commitValid_o && commitIdx < acceptCount |-> commitRd_o == expRd[commitIdx])
        else begin
            errorCount++;
            $display("ERROR %0t: commit %0d has rd %0d, expected %0d", $time,
                     $sampled(commitIdx), $sampled(commitRd_o), expRd[$sampled(commitIdx)]);
        end

    commitDataMatches: assert property (@(posedge clk) disable iff (reset_i)
        commitValid_o && commitIdx < acceptCount |-> commitData_o == expData[commitIdx])
        else begin
            errorCount++;
            $display("ERROR %0t: commit %0d has data %h, expected %h", $time,
                     $sampled(commitIdx), $sampled(commitData_o),
                     expData[$sampled(commitIdx)]);
        end

    commitLatency: assert property (@(posedge clk) disable iff (reset_i)
        commitValid_o && commitIdx < acceptCount
            |-> cycleCount - acceptCycle[commitIdx] >= MIN_LATENCY)
        else begin
            errorCount++;
            $display("%0t: instruction %0d committed sooner than %0d cycles after acceptance",
                     $time, $sampled(commitIdx), MIN_LATENCY);
        end

    // a full structure needs at least a queue's worth in flight
    stallHasCause: assert property (@(posedge clk) disable iff (reset_i)
        stall_o |-> acceptCount - commitIdx >= IQ_DEPTH)
        else begin
            errorCount++;
            $display("%0t: stall raised with only %0d instructions in flight", $time,
                     $sampled(acceptCount) - $sampled(commitIdx));
        end

    // ##########################################################
    // main sequence
    // ##########################################################

    initial begin
        logic [31:0] r;
        rngState    = 32'ha5b7_9ad6;
        acceptCount = 0;
        commitIdx   = 0;
        cycleCount  = 0;
        errorCount  = 0;
        stallCycles = 0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            refRegs[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            recentRd[i] = '0;
        end
        reset_i     = 1'b1;
        instValid_i = 1'b0;
        instOp_i    = ALU_ADD;
        instRd_i    = '0;
        instRs1_i   = '0;
        instRs2_i   = '0;
        instImm_i   = '0;

        repeat (16) @(posedge clk);
        #2;
        reset_i = 1'b0;
        idleCycles(4);

        // random mix with idle gaps
        for (int n = 0; n < NUM_INSTS - BURST_INSTS; n++) begin
            rollRandom(r);
            if (r[31:29] == 3'd0) begin
                idleCycles(int'(r[28:27]) + 1);
            end
            randomInst(1'b0);
        end

        // back-to-back dependency chain
        for (int n = 0; n < BURST_INSTS; n++) begin
            randomInst(1'b1);
        end
        instValid_i = 1'b0;

        wait (commitIdx == acceptCount);
        idleCycles(8);

        allCommitted: assert (commitIdx == acceptCount)
            else begin
                errorCount++;
                $display("%0d commits seen for %0d accepted instructions",
                         commitIdx, acceptCount);
            end

        $display("commits %0d of %0d, stall cycles %0d, errors %0d",
                 commitIdx, NUM_INSTS, stallCycles, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
backendPkg.sv
renameStage.sv
intIssueQueue.sv
intExecute.sv
reorderBuffer.sv
backend.sv
backendTb.sv

// ==== intExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

module intExecute import backendPkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  issueValid_i,
    input  aluOp_e                issueOp_i,
    input  logic [PHYS_IDX_W-1:0] issuePrs1_i,
    input  logic [PHYS_IDX_W-1:0] issuePrs2_i,
    input  logic [IMM_W-1:0]      issueImm_i,
    input  logic [PHYS_IDX_W-1:0] issuePrd_i,
    input  logic [ROB_IDX_W-1:0]  issueRobIdx_i,
    output logic                  wbValid_o,
    output logic [PHYS_IDX_W-1:0] wbPrd_o,
    output logic [ROB_IDX_W-1:0]  wbRobIdx_o,
    output logic [XLEN-1:0]       wbData_o
);

    logic [XLEN-1:0] physRegs [PHYS_REGS];
    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] immExt;
    logic [XLEN-1:0] result;

    // operand read, bypass from the writeback being retired this cycle
    always_comb begin
        opA  = physRegs[issuePrs1_i];
        src2 = physRegs[issuePrs2_i];
        if (wbValid_o && wbPrd_o == issuePrs1_i) begin
            opA = wbData_o;
        end
        if (wbValid_o && wbPrd_o == issuePrs2_i) begin
            src2 = wbData_o;
        end
        // p0 results are dropped, so never forward them
        if (issuePrs1_i == '0) begin
            opA = '0;
        end
        if (issuePrs2_i == '0) begin
            src2 = '0;
        end
    end

    assign immExt = {{(XLEN-IMM_W){issueImm_i[IMM_W-1]}}, issueImm_i};
    assign opB    = (issueOp_i == ALU_ADDI) ? immExt : src2;

    always_comb begin
        case (issueOp_i)
            ALU_ADD, ALU_ADDI: result = opA + opB;
            ALU_SUB:           result = opA - opB;
            ALU_AND:           result = opA & opB;
            ALU_OR:            result = opA | opB;
            ALU_XOR:           result = opA ^ opB;
            ALU_SLL:           result = opA << opB[4:0];
            ALU_SRL:           result = opA >> opB[4:0];
            default:           result = '0;
        endcase
    end

    // ##########################################################
    // writeback
    // ##########################################################

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wbValid_o <= 1'b0;
        end else begin
            wbValid_o <= issueValid_i;
        end
    end

    always_ff @(posedge clk) begin
        wbPrd_o    <= issuePrd_i;
        wbRobIdx_o <= issueRobIdx_i;
        wbData_o   <= result;
    end

    // architectural state starts at zero
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                physRegs[i] <= '0;
            end
        end else if (wbValid_o && wbPrd_o != '0) begin
            physRegs[wbPrd_o] <= wbData_o;
        end
    end

endmodule

`default_nettype wire

// ==== intIssueQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module intIssueQueue import backendPkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  dispatchValid_i,
    input  aluOp_e                dispOp_i,
    input  logic [PHYS_IDX_W-1:0] dispPrs1_i,
    input  logic [PHYS_IDX_W-1:0] dispPrs2_i,
    input  logic                  dispRs1Ready_i,
    input  logic                  dispRs2Ready_i,
    input  logic [PHYS_IDX_W-1:0] dispPrd_i,
    input  logic [IMM_W-1:0]      dispImm_i,
    input  logic [ROB_IDX_W-1:0]  dispRobIdx_i,
    input  logic [ROB_IDX_W-1:0]  robHead_i,
    input  logic                  wbValid_i,
    input  logic [PHYS_IDX_W-1:0] wbPrd_i,
    output logic                  iqFull_o,
    output logic                  issueValid_o,
    output aluOp_e                issueOp_o,
    output logic [PHYS_IDX_W-1:0] issuePrs1_o,
    output logic [PHYS_IDX_W-1:0] issuePrs2_o,
    output logic [IMM_W-1:0]      issueImm_o,
    output logic [PHYS_IDX_W-1:0] issuePrd_o,
    output logic [ROB_IDX_W-1:0]  issueRobIdx_o
);

    logic [IQ_DEPTH-1:0]   iqValid;
    logic [IQ_DEPTH-1:0]   iqRdy1;
    logic [IQ_DEPTH-1:0]   iqRdy2;
    aluOp_e                iqOp     [IQ_DEPTH];
    logic [PHYS_IDX_W-1:0] iqPrs1   [IQ_DEPTH];
    logic [PHYS_IDX_W-1:0] iqPrs2   [IQ_DEPTH];
    logic [PHYS_IDX_W-1:0] iqPrd    [IQ_DEPTH];
    logic [IMM_W-1:0]      iqImm    [IQ_DEPTH];
    logic [ROB_IDX_W-1:0]  iqRobIdx [IQ_DEPTH];

    logic [IQ_DEPTH-1:0]   canIssue;
    logic [IQ_IDX_W-1:0]   allocSlot;
    logic [IQ_IDX_W-1:0]   issueSlot;
    logic [IQ_IDX_W:0]     numValid;
    logic [IQ_DEPTH-1:0]   producerPending;

    // ##########################################################
    // wakeup and select
    // ##########################################################

    // same-cycle writeback wakes an entry and execute bypasses the value
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            canIssue[i] = iqValid[i]
                          && (iqRdy1[i] || (wbValid_i && wbPrd_i == iqPrs1[i]))
                          && (iqRdy2[i] || (wbValid_i && wbPrd_i == iqPrs2[i]));
        end
    end

    // oldest by distance from rob head
    always_comb begin
        logic [ROB_IDX_W-1:0] age;
        logic [ROB_IDX_W-1:0] bestAge;
        issueValid_o = 1'b0;
        issueSlot    = '0;
        bestAge      = '1;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            age = iqRobIdx[i] - robHead_i;
            if (canIssue[i] && (!issueValid_o || age < bestAge)) begin
                issueValid_o = 1'b1;
                issueSlot    = IQ_IDX_W'(i);
                bestAge      = age;
            end
        end
    end

    // lowest free slot and occupancy
    always_comb begin
        allocSlot = '0;
        numValid  = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!iqValid[i]) begin
                allocSlot = IQ_IDX_W'(i);
            end
            numValid = numValid + (IQ_IDX_W+1)'(iqValid[i]);
        end
    end

    // an instruction in the dispatch register still needs a slot
    assign iqFull_o = (numValid + (IQ_IDX_W+1)'(dispatchValid_i))
                      >= (IQ_IDX_W+1)'(IQ_DEPTH);

    assign issueOp_o     = iqOp[issueSlot];
    assign issuePrs1_o   = iqPrs1[issueSlot];
    assign issuePrs2_o   = iqPrs2[issueSlot];
    assign issueImm_o    = iqImm[issueSlot];
    assign issuePrd_o    = iqPrd[issueSlot];
    assign issueRobIdx_o = iqRobIdx[issueSlot];

    // ##########################################################
    // entry storage
    // ##########################################################

    always_ff @(posedge clk) begin
        if (reset_i) begin
            iqValid <= '0;
        end else begin
            if (issueValid_o) begin
                iqValid[issueSlot] <= 1'b0;
            end
            if (dispatchValid_i) begin
                iqValid[allocSlot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (wbValid_i && wbPrd_i == iqPrs1[i]) begin
                iqRdy1[i] <= 1'b1;
            end
            if (wbValid_i && wbPrd_i == iqPrs2[i]) begin
                iqRdy2[i] <= 1'b1;
            end
        end
        if (dispatchValid_i) begin
            iqOp[allocSlot]     <= dispOp_i;
            iqPrs1[allocSlot]   <= dispPrs1_i;
            iqPrs2[allocSlot]   <= dispPrs2_i;
            iqRdy1[allocSlot]   <= dispRs1Ready_i || (wbValid_i && wbPrd_i == dispPrs1_i);
            iqRdy2[allocSlot]   <= dispRs2Ready_i || (wbValid_i && wbPrd_i == dispPrs2_i);
            iqPrd[allocSlot]    <= dispPrd_i;
            iqImm[allocSlot]    <= dispImm_i;
            iqRobIdx[allocSlot] <= dispRobIdx_i;
        end
    end

    // a producer still waiting in the queue has not written its result
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            producerPending[i] = iqValid[i] && iqPrd[i] != '0
                                 && (iqPrd[i] == issuePrs1_o
                                     || (issueOp_o != ALU_ADDI && iqPrd[i] == issuePrs2_o));
        end
    end

    issueOnlyWhenReady: assert property (@(posedge clk) disable iff (reset_i)
        issueValid_o |-> producerPending == '0);

endmodule

`default_nettype wire

// ==== renameStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module renameStage import backendPkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  instValid_i,
    input  aluOp_e                instOp_i,
    input  logic [ARCH_IDX_W-1:0] instRd_i,
    input  logic [ARCH_IDX_W-1:0] instRs1_i,
    input  logic [ARCH_IDX_W-1:0] instRs2_i,
    input  logic [IMM_W-1:0]      instImm_i,
    input  logic                  wbValid_i,
    input  logic [PHYS_IDX_W-1:0] wbPrd_i,
    input  logic                  commitValid_i,
    input  logic [PHYS_IDX_W-1:0] commitOldPrd_i,
    output logic                  renameFull_o,
    output logic                  dispatchValid_o,
    output aluOp_e                dispOp_o,
    output logic [PHYS_IDX_W-1:0] dispPrs1_o,
    output logic [PHYS_IDX_W-1:0] dispPrs2_o,
    output logic                  dispRs1Ready_o,
    output logic                  dispRs2Ready_o,
    output logic [PHYS_IDX_W-1:0] dispPrd_o,
    output logic [PHYS_IDX_W-1:0] dispOldPrd_o,
    output logic [ARCH_IDX_W-1:0] dispRd_o,
    output logic [IMM_W-1:0]      dispImm_o
);

    logic [PHYS_IDX_W-1:0] aliasTable [ARCH_REGS];
    logic [PHYS_IDX_W-1:0] freeList [FREE_DEPTH];
    logic [FREE_IDX_W-1:0] freeHead;
    logic [FREE_IDX_W-1:0] freeTail;
    logic [FREE_IDX_W:0]   freeCount;
    logic [PHYS_REGS-1:0]  busy;

    logic                  allocate;
    logic                  freeOld;
    logic [PHYS_IDX_W-1:0] src1;
    logic [PHYS_IDX_W-1:0] src2;
    logic                  src1Ready;
    logic                  src2Ready;

    // rd zero keeps p0 and takes nothing from the free list
    assign allocate     = instValid_i && (instRd_i != '0);
    assign freeOld      = commitValid_i && (commitOldPrd_i != '0);
    assign renameFull_o = (freeCount == '0);

    assign src1 = aliasTable[instRs1_i];
    assign src2 = aliasTable[instRs2_i];

    // a tag on the writeback bus this cycle counts as ready
    assign src1Ready = !busy[src1] || (wbValid_i && wbPrd_i == src1);
    assign src2Ready = (instOp_i == ALU_ADDI) || !busy[src2]
                       || (wbValid_i && wbPrd_i == src2);

    // ##########################################################
    // alias table, free list, busy table
    // ##########################################################

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                aliasTable[i] <= PHYS_IDX_W'(i);
            end
            for (int i = 0; i < FREE_DEPTH; i++) begin
                freeList[i] <= PHYS_IDX_W'(ARCH_REGS + i);
            end
            freeHead  <= '0;
            freeTail  <= '0;
            freeCount <= (FREE_IDX_W+1)'(FREE_DEPTH);
            busy      <= '0;
        end else begin
            if (wbValid_i) begin
                busy[wbPrd_i] <= 1'b0;
            end
            if (allocate) begin
                aliasTable[instRd_i]     <= freeList[freeHead];
                busy[freeList[freeHead]] <= 1'b1;
                freeHead                 <= freeHead + 1'b1;
            end
            if (freeOld) begin
                freeList[freeTail] <= commitOldPrd_i;
                freeTail           <= freeTail + 1'b1;
            end
            freeCount <= freeCount + (FREE_IDX_W+1)'(freeOld)
                         - (FREE_IDX_W+1)'(allocate);
        end
    end

    // dispatch register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dispatchValid_o <= 1'b0;
        end else begin
            dispatchValid_o <= instValid_i;
        end
    end

    always_ff @(posedge clk) begin
        dispOp_o       <= instOp_i;
        dispPrs1_o     <= src1;
        dispPrs2_o     <= src2;
        dispRs1Ready_o <= src1Ready;
        dispRs2Ready_o <= src2Ready;
        dispPrd_o      <= allocate ? freeList[freeHead] : '0;
        dispOldPrd_o   <= aliasTable[instRd_i];
        dispRd_o       <= instRd_i;
        dispImm_o      <= instImm_i;
    end

    // top-level stall must keep allocation off an empty list
    freeListUnderflow: assert property (@(posedge clk) disable iff (reset_i)
        allocate |-> freeCount != '0);

    freeListOverflow: assert property (@(posedge clk) disable iff (reset_i)
        freeOld && !allocate |-> freeCount < FREE_DEPTH);

endmodule

`default_nettype wire

// ==== reorderBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorderBuffer import backendPkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  dispatchValid_i,
    input  logic [ARCH_IDX_W-1:0] dispRd_i,
    input  logic [PHYS_IDX_W-1:0] dispOldPrd_i,
    input  logic                  wbValid_i,
    input  logic [ROB_IDX_W-1:0]  wbRobIdx_i,
    input  logic [XLEN-1:0]       wbData_i,
    output logic                  robFull_o,
    output logic [ROB_IDX_W-1:0]  robTail_o,
    output logic [ROB_IDX_W-1:0]  robHead_o,
    output logic                  commitValid_o,
    output logic [ARCH_IDX_W-1:0] commitRd_o,
    output logic [XLEN-1:0]       commitData_o,
    output logic [PHYS_IDX_W-1:0] commitOldPrd_o
);

    logic [ROB_DEPTH-1:0]  robValid;
    logic [ROB_DEPTH-1:0]  robDone;
    logic [ARCH_IDX_W-1:0] robRd     [ROB_DEPTH];
    logic [PHYS_IDX_W-1:0] robOldPrd [ROB_DEPTH];
    logic [XLEN-1:0]       robData   [ROB_DEPTH];

    logic [ROB_IDX_W-1:0]  head;
    logic [ROB_IDX_W-1:0]  tail;
    logic [ROB_IDX_W:0]    count;

    assign robHead_o = head;
    assign robTail_o = tail;

    // leave room for the instruction sitting in the dispatch register
    assign robFull_o = (count + (ROB_IDX_W+1)'(dispatchValid_i))
                       >= (ROB_IDX_W+1)'(ROB_DEPTH);

    // in-order commit from the head
    assign commitValid_o  = robValid[head] && robDone[head];
    assign commitRd_o     = robRd[head];
    assign commitData_o   = robData[head];
    assign commitOldPrd_o = robOldPrd[head];

    // ##########################################################
    // pointers and status
    // ##########################################################

    always_ff @(posedge clk) begin
        if (reset_i) begin
            robValid <= '0;
            robDone  <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            if (wbValid_i) begin
                robDone[wbRobIdx_i] <= 1'b1;
            end
            if (commitValid_o) begin
                robValid[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            if (dispatchValid_i) begin
                robValid[tail] <= 1'b1;
                robDone[tail]  <= 1'b0;
                tail           <= tail + 1'b1;
            end
            count <= count + (ROB_IDX_W+1)'(dispatchValid_i)
                     - (ROB_IDX_W+1)'(commitValid_o);
        end
    end

    always_ff @(posedge clk) begin
        if (dispatchValid_i) begin
            robRd[tail]     <= dispRd_i;
            robOldPrd[tail] <= dispOldPrd_i;
        end
        if (wbValid_i) begin
            robData[wbRobIdx_i] <= wbData_i;
        end
    end

    // input stall has to account for the rename register
    noDispatchWhenFull: assert property (@(posedge clk) disable iff (reset_i)
        dispatchValid_i |-> count < ROB_DEPTH);

    wbTargetsLiveEntry: assert property (@(posedge clk) disable iff (reset_i)
        wbValid_i |-> robValid[wbRobIdx_i] && !robDone[wbRobIdx_i]);

endmodule

`default_nettype wire
